/* rvCore_cfg.svh */
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// Address of the first instruction fetched after reset
`define RV_RESET_PC 32'h0000_0000

// Architectural integer registers, x0 included
`define RV_NUM_REGS 32

// Longest wait for ack that the bus checks tolerate
// Counted in cycles from the rising edge of cyc
`define RV_BUS_TIMEOUT 16

`endif

/* rvCorePkg.sv */
`default_nettype none

package rvCorePkg;

    // Major opcodes, bits [6:0] of the instruction word
    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opImm    = 7'b0010011,
        opReg    = 7'b0110011,
        opSystem = 7'b1110011,
        opFence  = 7'b0001111
    } opcodeT;

    // Exact operation performed by the ALU
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluSrl,
        aluSra,
        aluPassB
    } aluOpT;

    // Sequencer phases, one instruction in flight
    typedef enum logic [2:0] {
        phFetch,
        phDecode,
        phExecute,
        phMemory,
        phWriteback,
        phHalt
    } phaseT;

    // Decode output bundle
    typedef struct packed {
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;
        logic [31:0] pc;
        aluOpT       aluOp;
        logic        aluSrcImm;
        logic        aluSrcPc;
        logic        regWrite;
        logic        memRead;
        logic        memWrite;
        logic        isBranch;
        logic        isJal;
        logic        isJalr;
        logic [2:0]  branchFunc;
        logic        isHalt;
    } decodedInstT;

    // Wishbone master outputs
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] dat;
    } wbMasterT;

    // Wishbone slave outputs
    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
    } wbSlaveT;

endpackage

`default_nettype wire

/* fetchUnit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rvCore_cfg.svh"

module fetchUnit
    import rvCorePkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        fetchStart,
    input  logic        pcLoad,
    input  logic [31:0] nextPc,
    output logic [31:0] pc,
    output wbMasterT    iBusOut,
    input  wbSlaveT     iBusIn,
    output logic        fetchDone,
    output logic [31:0] instWord
);

    // Open bus cycle
    logic cycReg;

    // Program counter, updated only at writeback
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            pc <= `RV_RESET_PC;
        else if (pcLoad)
            pc <= nextPc;
    end

    // One read per fetchStart, dropped the cycle after ack
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            cycReg <= 1'b0;
        else if (fetchStart)
            cycReg <= 1'b1;
        else if (iBusIn.ack)
            cycReg <= 1'b0;
    end

    // Read only, full word lanes
    always_comb
    begin
        iBusOut.cyc = cycReg;
        iBusOut.stb = cycReg;
        iBusOut.we  = 1'b0;
        iBusOut.sel = 4'hF;
        iBusOut.adr = pc;
        iBusOut.dat = '0;
    end

    // Ack data goes straight to decode
    assign fetchDone = cycReg && iBusIn.ack;
    assign instWord  = iBusIn.dat;

    // Strobe never outside a cycle
    assert property (@(posedge clk) disable iff (rst) iBusOut.stb |-> iBusOut.cyc)
        else $error("iBus stb without cyc");

    // Request held until the slave answers
    assert property (@(posedge clk) disable iff (rst)
        iBusOut.cyc && !iBusIn.ack |=> iBusOut.cyc && $stable(iBusOut.adr))
        else $error("iBus request dropped before ack");

    // PC keeps word alignment after every jump
    assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("PC not word aligned");

endmodule

`default_nettype wire

/* decodeStage.sv */
`timescale 1ns/100ps
`default_nettype none

module decodeStage
    import rvCorePkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        fetchDone,
    input  logic [31:0] instWord,
    input  logic [31:0] pc,
    output decodedInstT dec
);

    logic [31:0] instReg;
    logic [31:0] pcReg;
    opcodeT      opcode;
    logic [2:0]  func3;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immU;
    logic [31:0] immJ;

    // ALU op shared by register and immediate arithmetic
    function automatic aluOpT aluFromFunc3(input logic [2:0] f3, input logic alt);
        aluOpT op;
        case (f3)
            3'b000:  op = alt ? aluSub : aluAdd;
            3'b001:  op = aluSll;
            3'b010:  op = aluSlt;
            3'b100:  op = aluXor;
            3'b101:  op = alt ? aluSra : aluSrl;
            3'b110:  op = aluOr;
            3'b111:  op = aluAnd;
            default: op = aluAdd;
        endcase
        return op;
    endfunction

    // Instruction register with its PC
    // Cleared word has opcode 0 and decodes as NOP
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            instReg <= '0;
            pcReg   <= '0;
        end
        else if (fetchDone)
        begin
            instReg <= instWord;
            pcReg   <= pc;
        end
    end

    assign opcode = opcodeT'(instReg[6:0]);
    assign func3  = instReg[14:12];

    // Sign-extended immediates, one per format
    assign immI = {{20{instReg[31]}}, instReg[31:20]};
    assign immS = {{20{instReg[31]}}, instReg[31:25], instReg[11:7]};
    assign immB = {{19{instReg[31]}}, instReg[31], instReg[7], instReg[30:25],
                   instReg[11:8], 1'b0};
    assign immU = {instReg[31:12], 12'b0};
    assign immJ = {{11{instReg[31]}}, instReg[31], instReg[19:12], instReg[20],
                   instReg[30:21], 1'b0};

    always_comb
    begin
        // Defaults give a NOP with every write off
        dec            = '0;
        dec.rs1        = instReg[19:15];
        dec.rs2        = instReg[24:20];
        dec.rd         = instReg[11:7];
        dec.pc         = pcReg;
        dec.aluOp      = aluAdd;
        dec.branchFunc = func3;

        case (opcode)
            opLui:
            begin
                dec.imm       = immU;
                dec.aluOp     = aluPassB;
                dec.aluSrcImm = 1'b1;
                dec.regWrite  = 1'b1;
            end
            opAuipc:
            begin
                dec.imm       = immU;
                dec.aluSrcPc  = 1'b1;
                dec.aluSrcImm = 1'b1;
                dec.regWrite  = 1'b1;
            end
            // ALU forms the target as pc + imm
            opJal:
            begin
                dec.imm       = immJ;
                dec.aluSrcPc  = 1'b1;
                dec.aluSrcImm = 1'b1;
                dec.regWrite  = 1'b1;
                dec.isJal     = 1'b1;
            end
            // Target rs1 + imm, bit 0 cleared in execute
            opJalr:
            begin
                dec.imm       = immI;
                dec.aluSrcImm = 1'b1;
                dec.regWrite  = 1'b1;
                dec.isJalr    = 1'b1;
            end
            // Compare happens beside the ALU
            opBranch:
            begin
                dec.imm       = immB;
                dec.aluSrcPc  = 1'b1;
                dec.aluSrcImm = 1'b1;
                dec.isBranch  = 1'b1;
            end
            // Word access only
            opLoad:
            begin
                dec.imm       = immI;
                dec.aluSrcImm = 1'b1;
                dec.regWrite  = 1'b1;
                dec.memRead   = 1'b1;
            end
            opStore:
            begin
                dec.imm       = immS;
                dec.aluSrcImm = 1'b1;
                dec.memWrite  = 1'b1;
            end
            // SLTIU left out, stays a NOP
            opImm:
            begin
                dec.imm       = immI;
                dec.aluSrcImm = 1'b1;
                dec.aluOp     = aluFromFunc3(func3, (func3 == 3'b101) && instReg[30]);
                dec.regWrite  = (func3 != 3'b011);
            end
            // Bit 30 picks SUB and SRA, SLTU left out
            opReg:
            begin
                dec.aluOp    = aluFromFunc3(func3, instReg[30]);
                dec.regWrite = (func3 != 3'b011);
            end
            // ECALL and EBREAK
            opSystem:
                dec.isHalt = (func3 == 3'b000);
            default:
                dec.isHalt = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rvCore_cfg.svh"

module regFile (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        writeEn,
    input  logic [31:0] writeData,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [`RV_NUM_REGS];

    // Synchronous write, x0 never written
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < `RV_NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (writeEn && (rd != 5'd0))
            regs[rd] <= writeData;
    end

    // Asynchronous reads
    // x0 forced to zero on the read side too
    assign rdata1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

`default_nettype wire

/* executeUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module executeUnit
    import rvCorePkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        executeEn,
    input  decodedInstT dec,
    input  logic [31:0] rdata1,
    input  logic [31:0] rdata2,
    output logic [31:0] aluResult,
    output logic [31:0] storeData,
    output logic [31:0] nextPc
);

    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] aluOut;
    logic [31:0] pcPlus4;
    logic        cond;
    logic        takeBranch;

    // Operand select
    assign opA = dec.aluSrcPc ? dec.pc : rdata1;
    assign opB = dec.aluSrcImm ? dec.imm : rdata2;

    always_comb
    begin
        case (dec.aluOp)
            aluAdd:   aluOut = opA + opB;
            aluSub:   aluOut = opA - opB;
            aluAnd:   aluOut = opA & opB;
            aluOr:    aluOut = opA | opB;
            aluXor:   aluOut = opA ^ opB;
            aluSlt:   aluOut = {31'd0, $signed(opA) < $signed(opB)};
            aluSll:   aluOut = opA << opB[4:0];
            aluSrl:   aluOut = opA >> opB[4:0];
            aluSra:   aluOut = $unsigned($signed(opA) >>> opB[4:0]);
            aluPassB: aluOut = opB;
            default:  aluOut = '0;
        endcase
    end

    // Branch condition on the register operands
    // Unsigned compares are not supported, never taken
    always_comb
    begin
        case (dec.branchFunc)
            3'b000:  cond = (rdata1 == rdata2);
            3'b001:  cond = (rdata1 != rdata2);
            3'b100:  cond = ($signed(rdata1) < $signed(rdata2));
            3'b101:  cond = ($signed(rdata1) >= $signed(rdata2));
            default: cond = 1'b0;
        endcase
    end

    assign takeBranch = dec.isBranch && cond;
    assign pcPlus4    = dec.pc + 32'd4;

    // Results held through memory and writeback
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            aluResult <= '0;
            storeData <= '0;
            nextPc    <= '0;
        end
        else if (executeEn)
        begin
            // Jumps write the link value
            aluResult <= (dec.isJal || dec.isJalr) ? pcPlus4 : aluOut;
            storeData <= rdata2;
            if (dec.isJal || takeBranch)
                nextPc <= aluOut;
            else if (dec.isJalr)
                nextPc <= {aluOut[31:1], 1'b0};
            else
                nextPc <= pcPlus4;
        end
    end

endmodule

`default_nettype wire

/* memAccess.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rvCore_cfg.svh"

module memAccess
    import rvCorePkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        memStart,
    input  decodedInstT dec,
    input  logic [31:0] addr,
    input  logic [31:0] storeData,
    output wbMasterT    dBusOut,
    input  wbSlaveT     dBusIn,
    output logic        memDone,
    output logic [31:0] loadData
);

    logic cycReg;

    // One transfer per memStart
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            cycReg <= 1'b0;
        else if (memStart)
            cycReg <= 1'b1;
        else if (dBusIn.ack)
            cycReg <= 1'b0;
    end

    // Address and data come from execute registers
    // They hold still while cyc is up
    always_comb
    begin
        dBusOut.cyc = cycReg;
        dBusOut.stb = cycReg;
        dBusOut.we  = dec.memWrite;
        dBusOut.sel = 4'hF;
        dBusOut.adr = addr;
        dBusOut.dat = storeData;
    end

    assign memDone = cycReg && dBusIn.ack;

    // Load data captured on ack
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            loadData <= '0;
        else if (cycReg && dBusIn.ack && dec.memRead)
            loadData <= dBusIn.dat;
    end

    assert property (@(posedge clk) disable iff (rst) dBusOut.stb |-> dBusOut.cyc)
        else $error("dBus stb without cyc");

    // Word access only
    assert property (@(posedge clk) disable iff (rst)
        dBusOut.cyc |-> dBusOut.adr[1:0] == 2'b00)
        else $error("dBus address not word aligned");

    // Slave must answer in bounded time
    assert property (@(posedge clk) disable iff (rst)
        $rose(dBusOut.cyc) |-> ##[0:`RV_BUS_TIMEOUT] dBusIn.ack)
        else $error("dBus ack timeout");

endmodule

`default_nettype wire

/* coreSequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module coreSequencer
    import rvCorePkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        fetchDone,
    input  logic        memDone,
    input  decodedInstT dec,
    output logic        fetchStart,
    output logic        decodeEn,
    output logic        executeEn,
    output logic        memStart,
    output logic        writeEn,
    output logic        pcLoad,
    output logic        halted
);

    phaseT phase;
    phaseT phaseNext;
    logic  fetchBusy;
    logic  memBusy;

    // Bus request already issued in the current phase
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            fetchBusy <= 1'b0;
            memBusy   <= 1'b0;
        end
        else
        begin
            if (fetchStart)
                fetchBusy <= 1'b1;
            else if (fetchDone)
                fetchBusy <= 1'b0;
            if (memStart)
                memBusy <= 1'b1;
            else if (memDone)
                memBusy <= 1'b0;
        end
    end

    always_comb
    begin
        phaseNext = phase;
        case (phase)
            phFetch:     if (fetchDone) phaseNext = phDecode;
            phDecode:    phaseNext = dec.isHalt ? phHalt : phExecute;
            // Memory phase only for LW and SW
            phExecute:   phaseNext = (dec.memRead || dec.memWrite) ? phMemory : phWriteback;
            phMemory:    if (memDone) phaseNext = phWriteback;
            phWriteback: phaseNext = phFetch;
            // Stays halted until reset
            default:     phaseNext = phHalt;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            phase <= phFetch;
        else
            phase <= phaseNext;
    end

    // One-cycle strobes
    assign fetchStart = (phase == phFetch) && !fetchBusy;
    assign decodeEn   = (phase == phDecode);
    assign executeEn  = (phase == phExecute);
    assign memStart   = (phase == phMemory) && !memBusy;
    assign writeEn    = (phase == phWriteback) && dec.regWrite;
    assign pcLoad     = (phase == phWriteback);
    assign halted     = (phase == phHalt);

endmodule

`default_nettype wire

/* rvCore.sv */
`timescale 1ns/100ps
`default_nettype none

module rvCore
    import rvCorePkg::*;
(
    input  logic     clk,
    input  logic     rst,
    output wbMasterT iBusOut,
    input  wbSlaveT  iBusIn,
    output wbMasterT dBusOut,
    input  wbSlaveT  dBusIn,
    output logic     halted
);

    decodedInstT dec;
    logic        fetchStart;
    logic        executeEn;
    logic        memStart;
    logic        writeEn;
    logic        pcLoad;
    logic        fetchDone;
    logic        memDone;
    logic [31:0] pc;
    logic [31:0] instWord;
    logic [31:0] nextPc;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic [31:0] aluResult;
    logic [31:0] storeData;
    logic [31:0] loadData;
    logic [31:0] writeData;

    // Writeback source
    assign writeData = dec.memRead ? loadData : aluResult;

    fetchUnit uFetch (
        .clk, .rst, .fetchStart, .pcLoad, .nextPc, .pc,
        .iBusOut, .iBusIn, .fetchDone, .instWord
    );

    decodeStage uDecode (.clk, .rst, .fetchDone, .instWord, .pc, .dec);

    regFile uRegs (
        .clk, .rst, .rs1(dec.rs1), .rs2(dec.rs2), .rd(dec.rd),
        .writeEn, .writeData, .rdata1, .rdata2
    );

    executeUnit uExec (
        .clk, .rst, .executeEn, .dec, .rdata1, .rdata2,
        .aluResult, .storeData, .nextPc
    );

    // Address is the registered ALU sum
    memAccess uMem (
        .clk, .rst, .memStart, .dec, .addr(aluResult), .storeData,
        .dBusOut, .dBusIn, .memDone, .loadData
    );

    // Decode captures on fetchDone, so the decode strobe has no load here
    coreSequencer uSeq (
        .clk, .rst, .fetchDone, .memDone, .dec,
        .fetchStart, .decodeEn(), .executeEn, .memStart, .writeEn, .pcLoad, .halted
    );

endmodule

`default_nettype wire

/* tbRvCore.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rvCore_cfg.svh"

module tbRvCore
    import rvCorePkg::*;
();

    // Byte addresses of the result areas, all below 2 KB for x0-relative SW
    localparam int resBase  = 'h400;
    localparam int copyBase = 'h600;
    localparam int markBase = 'h700;
    localparam int haltWait = 3000;

    logic     clk;
    logic     rst = 1'b1;
    wbMasterT iBusOut;
    wbMasterT dBusOut;
    wbSlaveT  iBusIn = '0;
    wbSlaveT  dBusIn = '0;
    logic     halted;

    // Program image written by the tests, copied into memory during reset
    logic [31:0] image [1024];
    logic [31:0] mem [1024];

    // Bus model state
    logic [31:0] lfsrState = 32'h2fcfe5b8;
    logic        rstAtEdge = 1'b1;
    logic [1:0]  iWait = '0;
    logic [1:0]  dWait = '0;
    logic        iBusy = 1'b0;
    logic        dBusy = 1'b0;

    // Test bookkeeping
    int          asmPtr;
    logic [31:0] expQ[$];
    int          checksPassed = 0;
    int          checksFailed = 0;
    int          testFails = 0;

    rvCore uut (
        .clk, .rst, .iBusOut, .iBusIn, .dBusOut, .dBusIn, .halted
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic lfsrBit();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    // Background word for untouched memory
    function automatic logic [31:0] fillWord(input int idx);
        return 32'hC0DE_0000 ^ idx;
    endfunction

    // One Wishbone classic slave step, ack lasts a single cycle
    task automatic serveBus(input wbMasterT req, inout wbSlaveT rsp,
                            inout logic [1:0] waitLeft, inout logic busy);
        if (rsp.ack)
        begin
            rsp.ack = 1'b0;
            busy    = 1'b0;
        end
        else if (req.cyc && req.stb)
        begin
            // New request draws 0 to 3 wait states
            if (!busy)
            begin
                busy        = 1'b1;
                waitLeft[1] = lfsrBit();
                waitLeft[0] = lfsrBit();
            end
            if (waitLeft == 2'd0)
            begin
                rsp.ack = 1'b1;
                rsp.dat = mem[req.adr[11:2]];
                if (req.we)
                    mem[req.adr[11:2]] = req.dat;
            end
            else
                waitLeft = waitLeft - 2'd1;
        end
    endtask

    // Shared memory behind both buses
    always @(posedge clk)
    begin
        rstAtEdge = rst;
        #1;
        if (rstAtEdge)
        begin
            mem    = image;
            iBusIn = '0;
            dBusIn = '0;
            iBusy  = 1'b0;
            dBusy  = 1'b0;
        end
        else
        begin
            serveBus(iBusOut, iBusIn, iWait, iBusy);
            serveBus(dBusOut, dBusIn, dWait, dBusy);
        end
    end

    // Instruction encoders
    function automatic logic [31:0] rType(input int f7, input int f3, input int rd,
                                          input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] iType(input int op, input int f3, input int rd,
                                          input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] sType(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] bType(input int f3, input int rs1, input int rs2,
                                          input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    // Upper immediate given already shifted into bits 31..12
    function automatic logic [31:0] uType(input int op, input int rd, input int imm);
        return {imm[31:12], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] jType(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6F};
    endfunction

    // Address of the next instruction to be emitted
    function automatic logic [31:0] here();
        return `RV_RESET_PC + asmPtr * 4;
    endfunction

    task automatic emit(input logic [31:0] word);
        image[asmPtr[9:0]] = word;
        asmPtr = asmPtr + 1;
    endtask

    // LUI plus ADDI, always two words so offsets stay predictable
    task automatic li(input int rd, input int value);
        logic [31:0] v;
        logic [31:0] up;
        v  = value;
        up = v + 32'h800;
        emit(uType('h37, rd, up));
        emit(iType('h13, 0, rd, rd, v));
    endtask

    // Next result slot gets register rs
    task automatic storeReg(input int rs, input logic [31:0] exp);
        emit(sType(rs, 0, resBase + expQ.size() * 4));
        expQ.push_back(exp);
    endtask

    // Instruction writing x10, then its result stored
    task automatic expectResult(input logic [31:0] inst, input logic [31:0] exp);
        emit(inst);
        storeReg(10, exp);
    endtask

    task automatic beginProgram();
        for (int i = 0; i < 1024; i++)
            image[i[9:0]] = fillWord(i);
        asmPtr = 0;
        expQ.delete();
        testFails = 0;
    endtask

    task automatic checkValue(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        assert (got === exp)
            checksPassed++;
        else
        begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            checksFailed++;
            testFails++;
        end
    endtask

    task automatic checkWord(input int addr, input logic [31:0] exp, input string what);
        checkValue(mem[addr[11:2]], exp, what);
    endtask

    task automatic checkResults();
        for (int k = 0; k < expQ.size(); k++)
            checkWord(resBase + k * 4, expQ[k], $sformatf("result word %0d", k));
    endtask

    task automatic resetCore();
        @(posedge clk);
        #1 rst = 1'b1;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
    endtask

    task automatic waitHalted(input string name);
        int n;
        n = 0;
        while (!halted && n < haltWait)
        begin
            @(negedge clk);
            n++;
        end
        if (!halted)
        begin
            $display("Test %s: core did not halt within %0d cycles", name, haltWait);
            checksFailed++;
            testFails++;
        end
    endtask

    task automatic runProgram(input string name);
        resetCore();
        waitHalted(name);
    endtask

    task automatic finishTest(input string name);
        $display("Test %s finished with %0d failed checks", name, testFails);
    endtask

    // Register and immediate ALU forms, negative operands and shifts by 31
    task automatic testAluOps();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        a = 32'h8765_4321;
        b = 32'd31;
        c = 32'hFFFF_FFFB;
        beginProgram();
        li(1, a);
        li(2, b);
        li(3, c);
        expectResult(rType('h00, 0, 10, 1, 3), a + c);
        expectResult(rType('h20, 0, 10, 1, 3), a - c);
        expectResult(rType('h00, 1, 10, 1, 2), a << b[4:0]);
        expectResult(rType('h00, 2, 10, 1, 3), {31'd0, $signed(a) < $signed(c)});
        expectResult(rType('h00, 2, 10, 3, 1), {31'd0, $signed(c) < $signed(a)});
        expectResult(rType('h00, 4, 10, 1, 3), a ^ c);
        expectResult(rType('h00, 5, 10, 1, 2), a >> b[4:0]);
        expectResult(rType('h20, 5, 10, 1, 2), $signed(a) >>> b[4:0]);
        expectResult(rType('h00, 6, 10, 1, 3), a | c);
        expectResult(rType('h00, 7, 10, 1, 3), a & c);
        // Immediate forms, 12-bit immediates sign extended
        expectResult(iType('h13, 0, 10, 1, -100), a - 32'd100);
        expectResult(iType('h13, 2, 10, 3, -4), {31'd0, $signed(c) < -4});
        expectResult(iType('h13, 4, 10, 1, 'h7FF), a ^ 32'h7FF);
        expectResult(iType('h13, 6, 10, 3, 'h123), c | 32'h123);
        expectResult(iType('h13, 7, 10, 1, -16), a & 32'hFFFF_FFF0);
        expectResult(iType('h13, 1, 10, 3, 31), c << 31);
        expectResult(iType('h13, 5, 10, 1, 31), a >> 31);
        expectResult(iType('h13, 5, 10, 1, 'h41F), $signed(a) >>> 31);
        emit(iType('h73, 0, 0, 0, 0));
        runProgram("aluOps");
        checkResults();
        finishTest("aluOps");
    endtask

    task automatic testUpper();
        logic [31:0] p;
        beginProgram();
        expectResult(uType('h37, 10, 'hABCDE000), 32'hABCDE000);
        p = here();
        expectResult(uType('h17, 10, 'h12345000), p + 32'h12345000);
        p = here();
        // Negative upper immediate wraps below the instruction
        expectResult(uType('h17, 10, 'hFFFFF000), p + 32'hFFFFF000);
        emit(iType('h73, 0, 0, 0, 0));
        runProgram("upper");
        checkResults();
        finishTest("upper");
    endtask

    // x10 is 1 if the branch skipped the next word, 2 if it fell through
    task automatic branchCase(input int f3, input int va, input int vb, input logic taken);
        li(7, va);
        li(8, vb);
        emit(iType('h13, 0, 10, 0, 1));
        emit(bType(f3, 7, 8, 8));
        emit(iType('h13, 0, 10, 0, 2));
        storeReg(10, taken ? 32'd1 : 32'd2);
    endtask

    task automatic testBranches();
        int n;
        int expSum;
        n = 10;
        expSum = 0;
        for (int i = 1; i <= n; i++)
            expSum += i;
        beginProgram();
        emit(iType('h13, 0, 1, 0, 0));
        emit(iType('h13, 0, 2, 0, 1));
        emit(iType('h13, 0, 3, 0, n + 1));
        // Sum loop closed by BNE
        emit(rType('h00, 0, 1, 1, 2));
        emit(iType('h13, 0, 2, 2, 1));
        emit(bType(1, 2, 3, -8));
        // Same sum closed by BLT
        emit(iType('h13, 0, 4, 0, 0));
        emit(iType('h13, 0, 5, 0, 1));
        emit(rType('h00, 0, 4, 4, 5));
        emit(iType('h13, 0, 5, 5, 1));
        emit(bType(4, 5, 3, -8));
        storeReg(1, expSum);
        storeReg(4, expSum);
        branchCase(0, 5, 5, 5 == 5);
        branchCase(0, 5, -3, 5 == -3);
        branchCase(5, 5, -3, 5 >= -3);
        branchCase(5, -3, 5, -3 >= 5);
        branchCase(5, 7, 7, 7 >= 7);
        emit(iType('h73, 0, 0, 0, 0));
        runProgram("branches");
        checkResults();
        finishTest("branches");
    endtask

    task automatic testJumps();
        logic [31:0] link1;
        logic [31:0] link2;
        logic [31:0] target;
        beginProgram();
        link1 = here() + 32'd4;
        emit(jType(1, 12));
        // Skipped by JAL
        emit(iType('h13, 0, 11, 0, 'h55));
        emit(sType(11, 0, markBase));
        storeReg(1, link1);
        // LI is two words, JALR one, then two skipped words
        target = here() + 32'd20;
        li(5, target);
        link2 = here() + 32'd4;
        // Offset 1 checks that bit 0 of the target is cleared
        emit(iType('h67, 0, 2, 5, 1));
        emit(iType('h13, 0, 11, 0, 'h66));
        emit(sType(11, 0, markBase + 4));
        storeReg(2, link2);
        emit(iType('h73, 0, 0, 0, 0));
        runProgram("jumps");
        checkResults();
        checkWord(markBase, fillWord(markBase / 4), "JAL skipped marker");
        checkWord(markBase + 4, fillWord(markBase / 4 + 1), "JALR skipped marker");
        finishTest("jumps");
    endtask

    task automatic testLoadStore();
        logic [31:0] vals [4];
        int          slots [4];
        vals = '{32'h1234_5678, 32'hFFFF_FFFF, 32'h8000_0001, 32'h0BAD_F00D};
        beginProgram();
        for (int k = 0; k < 4; k++)
        begin
            slots[k] = resBase + expQ.size() * 4;
            li(6, vals[k]);
            storeReg(6, vals[k]);
        end
        // Reload every word, then store copies
        for (int k = 0; k < 4; k++)
            emit(iType('h03, 2, 12 + k, 0, slots[k]));
        for (int k = 0; k < 4; k++)
            emit(sType(12 + k, 0, copyBase + k * 4));
        // x0 ignores writes
        emit(iType('h13, 0, 0, 0, 'h7AB));
        emit(uType('h37, 0, 'h12345000));
        storeReg(0, 32'd0);
        emit(iType('h73, 0, 0, 0, 0));
        runProgram("loadStore");
        checkResults();
        for (int k = 0; k < 4; k++)
            checkWord(copyBase + k * 4, vals[k], $sformatf("reloaded word %0d", k));
        finishTest("loadStore");
    endtask

    task automatic testResetHalt();
        int n;
        beginProgram();
        emit(iType('h13, 0, 1, 0, 1));
        emit(iType('h73, 0, 0, 0, 0));
        @(posedge clk);
        #1 rst = 1'b1;
        for (int i = 0; i < 4; i++)
        begin
            @(negedge clk);
            checkValue({31'd0, iBusOut.cyc}, 32'd0, "iBus cyc in reset");
            checkValue({31'd0, dBusOut.cyc}, 32'd0, "dBus cyc in reset");
            checkValue({31'd0, halted}, 32'd0, "halted in reset");
        end
        @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        checkValue({31'd0, halted}, 32'd0, "halted after reset");
        checkValue({31'd0, dBusOut.cyc}, 32'd0, "dBus cyc after reset");
        n = 0;
        while (!iBusOut.cyc && n < 20)
        begin
            @(negedge clk);
            n++;
        end
        if (!iBusOut.cyc)
        begin
            $display("Test resetHalt: no instruction fetch started after reset");
            checksFailed++;
            testFails++;
        end
        else
            checkValue(iBusOut.adr, `RV_RESET_PC, "first fetch address");
        waitHalted("resetHalt");
        // Quiet buses once halted
        for (int i = 0; i < 40; i++)
        begin
            @(negedge clk);
            checkValue({31'd0, iBusOut.cyc | dBusOut.cyc}, 32'd0, "bus cyc after halt");
        end
        finishTest("resetHalt");
    endtask

    initial
    begin
        testAluOps();
        testUpper();
        testBranches();
        testJumps();
        testLoadStore();
        testResetHalt();
        $display("Checks passed: %0d, checks failed: %0d", checksPassed, checksFailed);
        if (checksFailed == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
rvCorePkg.sv
fetchUnit.sv
decodeStage.sv
regFile.sv
executeUnit.sv
memAccess.sv
coreSequencer.sv
rvCore.sv
tbRvCore.sv

/* runSim.sh */
#!/bin/bash
# Build the core testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tbRvCore -f sim.f -o tbRvCore \
    > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/tbRvCore > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || { echo "No result line in sim.log"; exit 1; }
exit 0
